/* build.f */
+incdir+source
source/pkg_alu.sv
source/ma_unit.sv
source/idiv_unit.sv
source/cnvt_unit.sv
source/srl_unit.sv
source/wb_arbiter.sv
source/alu.sv
tests/tb_alu.sv

/* Makefile */
# Verilator build and run of the integer cluster testbench.

BIN = obj_dir/vtb_alu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module tb_alu -o vtb_alu

run: compile
	./$(BIN) | tee run.log
	@if grep -q "Testbench failed" run.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Testbench passed" run.log

clean:
	rm -rf obj_dir run.log

/* tests/tb_alu.sv */
/*
 Testbench for the integer cluster top.
 Commands are issued one at a time, so latency checks assume an idle cluster.
 Issue numbers wrap at 16; never more than a few results are outstanding.
*/
`timescale 1ns/100ps

`include "alu_consts.svh"

module tb_alu
	import pkg_alu::*;
();

	localparam int N_CMDS = 60;	// Upper bound on commands issued.
	localparam int STEPS = `ALU_DIV_STEPS;

	logic clock, arst_n, req, stall, ready, done;
	alu_op_t op;
	data_t src1, src2, src3, wb_data;
	index_t index, wb_index;
	issue_no_t wb_issue_no;

	integer seed = 95;
	int errors, tests_ok, tests_bad, test_err0, cycle, outstanding;
	issue_no_t tb_issue, next_order;
	logic check_lat, check_order;
	data_t exp_data [16];
	index_t exp_index [16];
	int exp_lat [16];
	int issue_cyc [16];
	logic pending [16];

	alu uut (.clock, .arst_n, .req, .op, .src1, .src2, .src3, .index, .stall,
		.ready, .done, .wb_data, .wb_index, .wb_issue_no);

	always #10 clock = !clock;
	always @(posedge clock) cycle <= cycle + 1;

	// ~~~~~~~~~~~~~~~~~~~~
	// Reference model.
	// ~~~~~~~~~~~~~~~~~~~~
	function automatic data_t expected_value(alu_op_t o, data_t a, data_t b, data_t c);
		logic [63:0] twice;
		int n;
		twice = {a, a} >> b[4:0];
		n = 32;
		for (int i = 0; i < 32; i++)
			if (a[i]) n = 31 - i;	// Highest set bit wins.
		case (o)
			OP_ADD:		return a + b;
			OP_SUB:		return a - b;
			OP_MUL:		return a * b;
			OP_MAC:		return a * b + c;
			OP_DIV:		return (b == 0) ? 32'hffff_ffff : a / b;
			OP_REM:		return (b == 0) ? a : a % b;
			OP_ABS:		return a[31] ? 0 - a : a;
			OP_NEG:		return 0 - a;
			OP_SEXT8:	return {{24{a[7]}}, a[7:0]};
			OP_CLZ:		return n;
			OP_SLL:		return a << b[4:0];
			OP_SRL:		return a >> b[4:0];
			OP_SRA:		return $signed(a) >>> b[4:0];
			default:	return twice[31:0];
		endcase
	endfunction

	function automatic int expected_latency(alu_op_t o, data_t b);
		if (o[3:2] == 2'b00) return 3;
		if (o[3:2] == 2'b01) return (b == 0) ? 1 : STEPS + 1;
		return 1;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// Checks.
	// ~~~~~~~~~~~~~~~~~~~~
	a_data: assert property (@(posedge clock) disable iff (!arst_n)
		done |-> wb_data == exp_data[wb_issue_no])
		else begin
			errors++;
			$display("Mismatch at %0t: wb_data expected %h, got %h", $time,
				exp_data[$sampled(wb_issue_no)], $sampled(wb_data));
		end

	a_index: assert property (@(posedge clock) disable iff (!arst_n)
		done |-> wb_index == exp_index[wb_issue_no])
		else begin
			errors++;
			$display("Mismatch at %0t: wb_index expected %0d, got %0d", $time,
				exp_index[$sampled(wb_issue_no)], $sampled(wb_index));
		end

	a_stall: assert property (@(posedge clock) disable iff (!arst_n) stall |-> !done)
		else begin
			errors++;
			$display("Writeback happened while stall was high at %0t", $time);
		end

	// Bookkeeping of each writeback.
	always @(negedge clock) begin
		if (arst_n && done) begin
			assert (pending[wb_issue_no]) else begin
				errors++;
				$display("Issue %0d written back but not outstanding at %0t",
					wb_issue_no, $time);
			end
			if (check_lat) assert (cycle - issue_cyc[wb_issue_no] == exp_lat[wb_issue_no])
				else begin
					errors++;
					$display("Mismatch at %0t: latency expected %0d, got %0d", $time,
						exp_lat[wb_issue_no], cycle - issue_cyc[wb_issue_no]);
				end
			if (check_order) begin
				assert (wb_issue_no == next_order) else begin
					errors++;
					$display("Mismatch at %0t: wb_issue_no expected %0d, got %0d", $time,
						next_order, wb_issue_no);
				end
				next_order = next_order + 1'b1;
			end
			if (pending[wb_issue_no]) outstanding--;
			pending[wb_issue_no] = 1'b0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Stimulus.
	// ~~~~~~~~~~~~~~~~~~~~
	task automatic issue_cmd(input alu_op_t o, input data_t a, input data_t b, input data_t c);
		do begin
			@(posedge clock);
			#2;
		end while (!ready);
		req = 1'b1;
		op = o;
		src1 = a;
		src2 = b;
		src3 = c;
		index = $random(seed);
		exp_data[tb_issue] = expected_value(o, a, b, c);
		exp_index[tb_issue] = index;
		exp_lat[tb_issue] = expected_latency(o, b);
		issue_cyc[tb_issue] = cycle;
		pending[tb_issue] = 1'b1;
		outstanding++;
		tb_issue = tb_issue + 1'b1;
		@(posedge clock);
		#2 req = 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (outstanding != 0 && waited < 4 * STEPS) begin
			@(posedge clock);
			#2 waited++;
		end
		if (outstanding != 0) begin
			errors++;
			$display("Results still outstanding after %0d cycles", waited);
			outstanding = 0;
			for (int i = 0; i < 16; i++) pending[i] = 1'b0;
		end
	endtask

	task automatic end_test(input string name);
		if (errors == test_err0) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", name, errors - test_err0);
		end
		test_err0 = errors;
	endtask

	initial begin
		#((N_CMDS * (STEPS + 4) + 200) * 20);
		$display("Watchdog timeout, the run did not finish in time");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		alu_op_t ops [14];
		data_t b;
		ops = '{OP_ADD, OP_SUB, OP_MUL, OP_MAC, OP_DIV, OP_REM, OP_ABS, OP_NEG,
			OP_SEXT8, OP_CLZ, OP_SLL, OP_SRL, OP_SRA, OP_ROR};
		clock = 0;
		arst_n = 0;
		req = 0;
		stall = 0;
		op = OP_ADD;
		src1 = '0;
		src2 = '0;
		src3 = '0;
		index = '0;
		errors = 0;
		tests_ok = 0;
		tests_bad = 0;
		test_err0 = 0;
		cycle = 0;
		outstanding = 0;
		tb_issue = '0;
		next_order = '0;
		check_lat = 1'b1;
		check_order = 1'b0;
		for (int i = 0; i < 16; i++) pending[i] = 1'b0;
		repeat (8) @(posedge clock);
		#2 arst_n = 1;

		repeat (4) begin
			@(negedge clock);
			assert (ready && !done) else begin
				errors++;
				$display("After reset ready is not high or done is not low");
			end
		end
		end_test("reset state");

		for (int i = 0; i < 12; i++) begin
			issue_cmd(ops[i % 4], $random(seed), $random(seed), $random(seed));
			drain();
		end
		end_test("multiply-add");

		for (int i = 0; i < 6; i++) begin
			b = (i % 3 == 2) ? '0 : $random(seed) >> (i * 5);	// Some zero divisors.
			issue_cmd(ops[4 + i % 2], $random(seed), b, '0);
			assert (!ready) else begin
				errors++;
				$display("ready was high while a division ran");
			end
			drain();
		end
		end_test("division");

		for (int i = 0; i < 16; i++) begin
			issue_cmd(ops[6 + i % 8], $random(seed) >> (i % 5 * 6), $random(seed), '0);
			drain();
		end
		end_test("conversion and shift");

		// A younger rotate finishes together with an older MUL.
		check_lat = 1'b0;
		check_order = 1'b1;
		next_order = tb_issue;
		issue_cmd(OP_MAC, $random(seed), $random(seed), $random(seed));
		issue_cmd(OP_MUL, $random(seed), $random(seed), '0);
		issue_cmd(OP_ROR, $random(seed), $random(seed), '0);
		issue_cmd(OP_DIV, $random(seed), '0, '0);
		issue_cmd(OP_SRA, $random(seed), $random(seed), '0);
		drain();
		check_order = 1'b0;
		end_test("oldest first");

		stall = 1'b1;
		issue_cmd(OP_ADD, $random(seed), $random(seed), '0);
		issue_cmd(OP_MAC, $random(seed), $random(seed), $random(seed));
		repeat (6) @(posedge clock);
		#2 assert (!ready) else begin
			errors++;
			$display("ready stayed high while results were held");
		end
		stall = 1'b0;
		drain();
		for (int i = 0; i < 8; i++) begin
			stall = $random(seed);
			issue_cmd(ops[$unsigned($random(seed)) % 14], $random(seed), $random(seed),
				$random(seed));
			repeat ($unsigned($random(seed)) % 6) @(posedge clock);
			#2 stall = 1'b0;
			drain();
		end
		end_test("back-pressure");

		$display("Tests passed: %0d, tests failed: %0d, errors: %0d",
			tests_ok, tests_bad, errors);
		if (tests_bad == 0 && errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* source/alu.sv */
/*
 Integer execution cluster top.
 The requester pulses req only while ready is high; done has no handshake.
 stall blocks writeback and eventually lowers ready.
*/
`timescale 1ns/100ps

module alu
	import pkg_alu::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		req,
	input	alu_op_t	op,
	input	data_t		src1,
	input	data_t		src2,
	input	data_t		src3,
	input	index_t		index,
	input	logic		stall,
	output	logic		ready,
	output	logic		done,
	output	data_t		wb_data,
	output	index_t		wb_index,
	output	issue_no_t	wb_issue_no
);

	unit_sel_t	unit;
	logic		accept;
	issue_no_t	issue_cnt;
	logic		en_ma, en_div, en_cnvt, en_srl;
	logic		ma_valid, div_valid, cnvt_valid, srl_valid;
	data_t		ma_result, div_result, cnvt_result, srl_result;
	index_t		ma_index, div_index, cnvt_index, srl_index;
	issue_no_t	ma_issue_no, div_issue_no, cnvt_issue_no, srl_issue_no;
	logic		ma_take, div_take, cnvt_take, srl_take;
	logic		ma_ready, div_ready, cnvt_ready, srl_ready;

	// ~~~~~~~~~~~~~~~~~~~~
	// Decode and issue.
	// ~~~~~~~~~~~~~~~~~~~~
	assign unit		= unit_sel_t'(op[3:2]);
	assign ready	= ma_ready && div_ready && cnvt_ready && srl_ready;
	assign accept	= req && ready;
	assign en_ma	= accept && (unit == UNIT_MA);
	assign en_div	= accept && (unit == UNIT_DIV);
	assign en_cnvt	= accept && (unit == UNIT_CNVT);
	assign en_srl	= accept && (unit == UNIT_SRL);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) issue_cnt <= '0;
		else if (accept) issue_cnt <= issue_cnt + 1'b1;	// Wraps.
	end

	ma_unit u_ma (.clock, .arst_n, .en(en_ma), .op, .src1, .src2, .src3, .index,
		.issue_no(issue_cnt), .take(ma_take), .valid(ma_valid), .result(ma_result),
		.wb_index(ma_index), .wb_issue_no(ma_issue_no), .can_accept(ma_ready));

	idiv_unit u_div (.clock, .arst_n, .en(en_div), .op, .src1, .src2, .index,
		.issue_no(issue_cnt), .take(div_take), .valid(div_valid), .result(div_result),
		.wb_index(div_index), .wb_issue_no(div_issue_no), .can_accept(div_ready));

	cnvt_unit u_cnvt (.clock, .arst_n, .en(en_cnvt), .op, .src1, .index,
		.issue_no(issue_cnt), .take(cnvt_take), .valid(cnvt_valid), .result(cnvt_result),
		.wb_index(cnvt_index), .wb_issue_no(cnvt_issue_no), .can_accept(cnvt_ready));

	srl_unit u_srl (.clock, .arst_n, .en(en_srl), .op, .src1, .src2, .index,
		.issue_no(issue_cnt), .take(srl_take), .valid(srl_valid), .result(srl_result),
		.wb_index(srl_index), .wb_issue_no(srl_issue_no), .can_accept(srl_ready));

	wb_arbiter u_arb (.issue_now(issue_cnt), .stall,
		.ma_valid, .div_valid, .cnvt_valid, .srl_valid,
		.ma_result, .div_result, .cnvt_result, .srl_result,
		.ma_index, .div_index, .cnvt_index, .srl_index,
		.ma_issue_no, .div_issue_no, .cnvt_issue_no, .srl_issue_no,
		.ma_take, .div_take, .cnvt_take, .srl_take,
		.done, .wb_data, .wb_index, .wb_issue_no);

	a_req_ready: assert property (@(posedge clock) disable iff (!arst_n) req |-> ready)
		else $error("alu: req while not ready");

endmodule

/* source/wb_arbiter.sv */
/*
 Oldest-first writeback select, purely combinational.
 Age is issue_now minus the result's issue number, so it is always at least one.
*/
`timescale 1ns/100ps

module wb_arbiter
	import pkg_alu::*;
(
	input	issue_no_t	issue_now,
	input	logic		stall,
	input	logic		ma_valid, div_valid, cnvt_valid, srl_valid,
	input	data_t		ma_result, div_result, cnvt_result, srl_result,
	input	index_t		ma_index, div_index, cnvt_index, srl_index,
	input	issue_no_t	ma_issue_no, div_issue_no, cnvt_issue_no, srl_issue_no,
	output	logic		ma_take, div_take, cnvt_take, srl_take,
	output	logic		done,
	output	data_t		wb_data,
	output	index_t		wb_index,
	output	issue_no_t	wb_issue_no
);

	logic [3:0]	valid_v;
	issue_no_t	issue_v [4];
	unit_sel_t	grant;

	assign valid_v		= {srl_valid, cnvt_valid, div_valid, ma_valid};
	assign issue_v[0]	= ma_issue_no;
	assign issue_v[1]	= div_issue_no;
	assign issue_v[2]	= cnvt_issue_no;
	assign issue_v[3]	= srl_issue_no;

	always_comb begin
		issue_no_t	age;
		issue_no_t	best_age;
		grant		= UNIT_MA;
		best_age	= '0;
		for (int i = 0; i < 4; i++) begin
			age = issue_now - issue_v[i];	// Wrapping difference.
			if (valid_v[i] && age > best_age) begin
				best_age	= age;
				grant		= unit_sel_t'(2'(i));
			end
		end
	end

	assign done			= (|valid_v) && !stall;
	assign ma_take		= done && (grant == UNIT_MA);
	assign div_take		= done && (grant == UNIT_DIV);
	assign cnvt_take	= done && (grant == UNIT_CNVT);
	assign srl_take		= done && (grant == UNIT_SRL);

	always_comb begin
		case (grant)
			UNIT_MA:	{wb_data, wb_index, wb_issue_no} = {ma_result, ma_index, ma_issue_no};
			UNIT_DIV:	{wb_data, wb_index, wb_issue_no} = {div_result, div_index, div_issue_no};
			UNIT_CNVT:	{wb_data, wb_index, wb_issue_no} = {cnvt_result, cnvt_index, cnvt_issue_no};
			default:	{wb_data, wb_index, wb_issue_no} = {srl_result, srl_index, srl_issue_no};
		endcase
	end

	// At most one unit releases its result, and only one that holds something.
	always_comb begin
		a_one_take: assert ($onehot0({srl_take, cnvt_take, div_take, ma_take}) &&
			!(|({srl_take, cnvt_take, div_take, ma_take} & ~valid_v)))
			else $error("wb_arbiter: bad take pattern");
	end

endmodule

/* source/srl_unit.sv */
/*
 Single-cycle shifts and rotate right.
 Only the low log2(ALU_DATA_W) bits of src2 set the amount.
*/
`timescale 1ns/100ps

`include "alu_consts.svh"

module srl_unit
	import pkg_alu::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		en,
	input	alu_op_t	op,
	input	data_t		src1,
	input	data_t		src2,
	input	index_t		index,
	input	issue_no_t	issue_no,
	input	logic		take,
	output	logic		valid,
	output	data_t		result,
	output	index_t		wb_index,
	output	issue_no_t	wb_issue_no,
	output	logic		can_accept
);

	localparam int SH_W = $clog2(`ALU_DATA_W);

	logic [SH_W-1:0]	amount;
	data_t				calc;

	assign amount = src2[SH_W-1:0];

	always_comb begin
		case (op)
			OP_SLL:		calc = src1 << amount;
			OP_SRL:		calc = src1 >> amount;
			OP_SRA:		calc = $signed(src1) >>> amount;
			default:	calc = (src1 >> amount) | (src1 << (`ALU_DATA_W - amount));	// OP_ROR.
		endcase
	end

	assign can_accept = !valid || take;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) valid <= 1'b0;
		else if (en) valid <= 1'b1;
		else if (take) valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (en) begin
			result		<= calc;
			wb_index	<= index;
			wb_issue_no	<= issue_no;
		end
	end

endmodule

/* source/cnvt_unit.sv */
/*
 Single-cycle abs, negate, byte sign-extend and count leading zeros.
 Abs of the most negative value wraps to itself.
*/
`timescale 1ns/100ps

`include "alu_consts.svh"

module cnvt_unit
	import pkg_alu::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		en,
	input	alu_op_t	op,
	input	data_t		src1,
	input	index_t		index,
	input	issue_no_t	issue_no,
	input	logic		take,
	output	logic		valid,
	output	data_t		result,
	output	index_t		wb_index,
	output	issue_no_t	wb_issue_no,
	output	logic		can_accept
);

	data_t calc;

	function automatic data_t count_lz(input data_t v);
		data_t	n;
		logic	found;
		n		= '0;
		found	= 1'b0;
		for (int i = `ALU_DATA_W - 1; i >= 0; i--) begin
			if (!found && !v[i]) n = n + 1'b1;
			else found = 1'b1;
		end
		return n;
	endfunction

	always_comb begin
		case (op)
			OP_ABS:		calc = src1[`ALU_DATA_W-1] ? -src1 : src1;
			OP_NEG:		calc = -src1;
			OP_SEXT8:	calc = {{(`ALU_DATA_W-8){src1[7]}}, src1[7:0]};
			default:	calc = count_lz(src1);	// OP_CLZ.
		endcase
	end

	assign can_accept = !valid || take;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) valid <= 1'b0;
		else if (en) valid <= 1'b1;
		else if (take) valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (en) begin
			result		<= calc;
			wb_index	<= index;
			wb_issue_no	<= issue_no;
		end
	end

endmodule

/* source/idiv_unit.sv */
/*
 Unsigned radix-2 restoring divider, one division at a time.
 Zero divisor gives an all-ones quotient and the dividend as remainder.
 Latency is ALU_DIV_STEPS+1 cycles, or one cycle for a zero divisor.
*/
`timescale 1ns/100ps

`include "alu_consts.svh"

module idiv_unit
	import pkg_alu::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		en,
	input	alu_op_t	op,
	input	data_t		src1,
	input	data_t		src2,
	input	index_t		index,
	input	issue_no_t	issue_no,
	input	logic		take,
	output	logic		valid,
	output	data_t		result,
	output	index_t		wb_index,
	output	issue_no_t	wb_issue_no,
	output	logic		can_accept
);

	localparam int CNT_W = $clog2(`ALU_DIV_STEPS);

	div_state_t				state;
	logic [CNT_W-1:0]		count;
	data_t					quot, rmd, divisor;
	logic					is_rem;
	logic [`ALU_DATA_W:0]	trial, diff;

	// One restoring step.
	assign trial	= {rmd, quot[`ALU_DATA_W-1]};
	assign diff		= trial - {1'b0, divisor};

	assign valid		= (state == DIV_DONE);
	assign can_accept	= (state == DIV_IDLE);
	assign result		= is_rem ? rmd : quot;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= DIV_IDLE;
		end else begin
			case (state)
				DIV_IDLE:	if (en) state <= (src2 == '0) ? DIV_DONE : DIV_RUN;
				DIV_RUN:	if (count == '0) state <= DIV_DONE;
				DIV_DONE:	if (take) state <= DIV_IDLE;
				default:	state <= DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == DIV_IDLE && en) begin
			is_rem		<= (op == OP_REM);
			wb_index	<= index;
			wb_issue_no	<= issue_no;
			divisor		<= src2;
			count		<= CNT_W'(`ALU_DIV_STEPS - 1);
			quot		<= (src2 == '0) ? '1 : src1;
			rmd			<= (src2 == '0) ? src1 : '0;
		end else if (state == DIV_RUN) begin
			count		<= count - 1'b1;
			quot		<= {quot[`ALU_DATA_W-2:0], !diff[`ALU_DATA_W]};	// Set bit if no borrow.
			rmd			<= diff[`ALU_DATA_W] ? trial[`ALU_DATA_W-1:0] : diff[`ALU_DATA_W-1:0];
		end
	end

endmodule

/* source/ma_unit.sv */
/*
 Three-stage add/sub/mul/mac pipeline, results wrap at the data width.
 The whole pipe freezes while the last stage holds an untaken result.
*/
`timescale 1ns/100ps

module ma_unit
	import pkg_alu::*;
(
	input	logic		clock,
	input	logic		arst_n,
	input	logic		en,
	input	alu_op_t	op,
	input	data_t		src1,
	input	data_t		src2,
	input	data_t		src3,
	input	index_t		index,
	input	issue_no_t	issue_no,
	input	logic		take,
	output	logic		valid,
	output	data_t		result,
	output	index_t		wb_index,
	output	issue_no_t	wb_issue_no,
	output	logic		can_accept
);

	logic		advance;
	logic		s1_valid, s2_valid;
	alu_op_t	s1_op;
	data_t		s1_a, s1_b, s1_c;
	index_t		s1_index, s2_index;
	issue_no_t	s1_issue, s2_issue;
	logic		s2_sub;
	data_t		s2_x, s2_y;

	assign advance		= !valid || take;	// Last stage empty or leaving.
	assign can_accept	= advance;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid	<= 1'b0;
			s2_valid	<= 1'b0;
			valid		<= 1'b0;
		end else if (advance) begin
			s1_valid	<= en;
			s2_valid	<= s1_valid;
			valid		<= s2_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			s1_op		<= op;
			s1_a		<= src1;
			s1_b		<= src2;
			s1_c		<= src3;
			s1_index	<= index;
			s1_issue	<= issue_no;
			// Product or pass-through.
			s2_sub		<= (s1_op == OP_SUB);
			s2_x		<= (s1_op == OP_MUL || s1_op == OP_MAC) ? s1_a * s1_b : s1_a;
			s2_y		<= (s1_op == OP_MUL) ? '0 : (s1_op == OP_MAC) ? s1_c : s1_b;
			s2_index	<= s1_index;
			s2_issue	<= s1_issue;
			result		<= s2_sub ? s2_x - s2_y : s2_x + s2_y;
			wb_index	<= s2_index;
			wb_issue_no	<= s2_issue;
		end
	end

	// A held result stays put until the arbiter takes it.
	a_hold: assert property (@(posedge clock) disable iff (!arst_n)
		valid && !take |=> valid && $stable(result) && $stable(wb_issue_no))
		else $error("ma_unit: held result changed without take");

endmodule

/* source/pkg_alu.sv */
/*
 Types for the integer execution cluster.
 Opcode bits [3:2] pick the unit and must stay in step with unit_sel_t.
*/

`include "alu_consts.svh"

package pkg_alu;

	typedef logic [`ALU_DATA_W-1:0]		data_t;
	typedef logic [`ALU_INDEX_W-1:0]	index_t;
	typedef logic [`ALU_ISSUE_W-1:0]	issue_no_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// Opcodes.
	// ~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [3:0] {
		OP_ADD		= 4'b0000,
		OP_SUB		= 4'b0001,
		OP_MUL		= 4'b0010,
		OP_MAC		= 4'b0011,
		OP_DIV		= 4'b0100,
		OP_REM		= 4'b0101,
		OP_ABS		= 4'b1000,
		OP_NEG		= 4'b1001,
		OP_SEXT8	= 4'b1010,
		OP_CLZ		= 4'b1011,
		OP_SLL		= 4'b1100,
		OP_SRL		= 4'b1101,
		OP_SRA		= 4'b1110,
		OP_ROR		= 4'b1111
	} alu_op_t;

	typedef enum logic [1:0] {UNIT_MA, UNIT_DIV, UNIT_CNVT, UNIT_SRL} unit_sel_t;

	typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_t;

endpackage

/* source/alu_consts.svh */
/*
 Widths and counts shared by the integer cluster.
 ALU_ISSUE_W must be wide enough that the six results in flight never alias.
 ALU_DIV_STEPS has to equal ALU_DATA_W for the divider to finish.
*/

`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Datapath widths.
// ~~~~~~~~~~~~~~~~~~~~
`define ALU_DATA_W		32
`define ALU_INDEX_W		5

// Issue numbers wrap. Ages compare by difference.
`define ALU_ISSUE_W		4

// ~~~~~~~~~~~~~~~~~~~~
// Divider.
// ~~~~~~~~~~~~~~~~~~~~
`define ALU_DIV_STEPS	`ALU_DATA_W

`endif
